//--- bench/remap_mem_tb.sv
module remap_mem_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import remap_pkg::*;

  logic                clk;
  logic                rst;
  logic                vwrite;
  logic [bit_addr-1:0] vwraddr;
  logic [width-1:0]    vdin;
  logic                vread;
  logic [bit_addr-1:0] vrdaddr;
  logic [width-1:0]    vdout;
  logic                ready;

  remap_mem_top remap_mem_top_i (
    .clk     (clk),
    .rst     (rst),
    .vwrite  (vwrite),
    .vwraddr (vwraddr),
    .vdin    (vdin),
    .vread   (vread),
    .vrdaddr (vrdaddr),
    .vdout   (vdout),
    .ready   (ready)
  );

  always #5 clk = ~clk;

  // stimulus table, one entry per cycle
  int                  t_tst [$];
  logic                t_we [$];
  logic [bit_addr-1:0] t_wa [$];
  logic [width-1:0]    t_d [$];
  logic                t_re [$];
  logic [bit_addr-1:0] t_ra [$];

  // pending read results
  time                 due_q [$];
  logic [width-1:0]    exp_q [$];
  int                  tst_q [$];
  logic [bit_addr-1:0] addr_q [$];

  logic [width-1:0] model [num_vbnk*num_vrow];
  logic [31:0]      rng = 32'd83721;
  logic             table_built = 1'b0;
  logic             ready_up = 1'b0;
  int               n_chk = 0;
  int               n_err = 0;
  int               test_err [7];

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [width-1:0] rand_word();
    rng = xorshift32(rng);
    return rng[width-1:0];
  endfunction

  function automatic logic [bit_addr-1:0] vaddr(int v, int r);
    return bit_addr'(v * num_vrow + r);
  endfunction

  task automatic add_row(input int tst, input logic we, input logic [bit_addr-1:0] wa,
                         input logic [width-1:0] d, input logic re,
                         input logic [bit_addr-1:0] ra);
    t_tst.push_back(tst);
    t_we.push_back(we);
    t_wa.push_back(wa);
    t_d.push_back(d);
    t_re.push_back(re);
    t_ra.push_back(ra);
  endtask

  task automatic build_table();
    logic [31:0]         ctl;
    logic [width-1:0]    d;
    logic [bit_addr-1:0] a;
    for (int i = 0; i < num_vbnk * num_vrow; i++) begin
      add_row(2, 1'b1, bit_addr'(i), rand_word(), 1'b0, '0);
      add_row(2, 1'b0, '0, '0, 1'b1, bit_addr'(i));
    end
    // same virtual bank, different rows, same cycle
    for (int i = 0; i < num_vrow; i++) begin
      add_row(3, 1'b1, vaddr(i % 4, i), rand_word(), 1'b1, vaddr(i % 4, (i + 5) % 16));
    end
    for (int i = 0; i < num_vrow; i++) begin
      add_row(3, 1'b0, '0, '0, 1'b1, vaddr(i % 4, i));
    end
    for (int v = 0; v < num_vbnk; v++) begin
      a = vaddr(v, 3 * v + 2);
      add_row(4, 1'b1, a, rand_word(), 1'b1, a);
      add_row(4, 1'b0, '0, '0, 1'b1, a);
    end
    // row 7 hit on adjacent cycles, map update forwarded
    add_row(5, 1'b1, vaddr(0, 7), rand_word(), 1'b1, vaddr(0, 3));
    add_row(5, 1'b1, vaddr(1, 7), rand_word(), 1'b1, vaddr(1, 9));
    add_row(5, 1'b1, vaddr(0, 7), rand_word(), 1'b1, vaddr(0, 7));
    add_row(5, 1'b1, vaddr(2, 7), rand_word(), 1'b1, vaddr(2, 1));
    add_row(5, 1'b1, vaddr(3, 7), rand_word(), 1'b1, vaddr(3, 12));
    for (int i = 0; i < num_vbnk * num_vrow; i++) begin
      add_row(5, 1'b0, '0, '0, 1'b1, bit_addr'(i));
    end
    for (int i = 0; i < 60; i++) begin
      rng = xorshift32(rng);
      ctl = rng;
      d = rand_word();
      add_row(6, ctl[31], ctl[bit_addr-1:0], d, ctl[30], ctl[2*bit_addr-1:bit_addr]);
    end
  endtask

  task automatic report_test(input int tst);
    $display("test %0d %s with %0d errors", tst, (test_err[tst] == 0) ? "passed" : "failed",
             test_err[tst]);
  endtask

  // idle the ports and drain outstanding reads
  task automatic finish_test(input int tst);
    @(posedge clk);
    vwrite <= 1'b0;
    vread  <= 1'b0;
    while (due_q.size() > 0) begin
      @(negedge clk);
      #1;
    end
    report_test(tst);
  endtask

  always @(negedge clk) begin
    if (ready_up && !ready) begin
      n_err++;
      $display("CHECK FAILED at %0t: ready fell after init", $time);
    end
    if (due_q.size() > 0 && due_q[0] == $time) begin
      n_chk++;
      if (vdout !== exp_q[0]) begin
        n_err++;
        test_err[tst_q[0]]++;
        $display("CHECK FAILED at %0t: read of 0x%0h gave 0x%0h, expected 0x%0h", $time,
                 addr_q[0], vdout, exp_q[0]);
      end
      void'(due_q.pop_front());
      void'(exp_q.pop_front());
      void'(tst_q.pop_front());
      void'(addr_q.pop_front());
    end
  end

  initial begin
    wait (table_built);
    #((4 + 16 + t_tst.size() + 20) * 10);
    $display("timeout: the run did not finish before the watchdog expired");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int cnt;
    int cur;
    clk     = 1'b0;
    rst     = 1'b1;
    vwrite  = 1'b0;
    vwraddr = '0;
    vdin    = '0;
    vread   = 1'b0;
    vrdaddr = '0;
    build_table();
    table_built = 1'b1;

    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      if (i == 3) begin
        rst <= 1'b0;
      end
      #1;
      n_chk++;
      if (ready) begin
        n_err++;
        test_err[1]++;
        $display("CHECK FAILED at %0t: ready high during reset", $time);
      end
    end
    cnt = 0;
    while (!ready && cnt < 40) begin
      @(posedge clk);
      #1;
      cnt++;
    end
    n_chk++;
    if (cnt != 17) begin
      n_err++;
      test_err[1]++;
      $display("CHECK FAILED at %0t: ready rose %0d cycles after reset, expected 17", $time, cnt);
    end
    ready_up = ready;
    report_test(1);

    cur = t_tst[0];
    for (int i = 0; i < t_tst.size(); i++) begin
      if (t_tst[i] != cur) begin
        finish_test(cur);
        cur = t_tst[i];
      end
      @(posedge clk);
      vwrite  <= t_we[i];
      vwraddr <= t_wa[i];
      vdin    <= t_d[i];
      vread   <= t_re[i];
      vrdaddr <= t_ra[i];
      // read sees the memory before this cycle's write
      if (t_re[i]) begin
        due_q.push_back($time + 25);
        exp_q.push_back(model[t_ra[i]]);
        tst_q.push_back(t_tst[i]);
        addr_q.push_back(t_ra[i]);
      end
      if (t_we[i]) begin
        model[t_wa[i]] = t_d[i];
      end
    end
    finish_test(cur);

    $display("%0d checks, %0d errors", n_chk, n_err);
    if (n_err == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- hw/bank_array.sv
module bank_array (
  input  logic                          clk,
  input  logic                          pread,
  input  logic [remap_pkg::bit_pbnk-1:0] prdbnk,
  input  logic [remap_pkg::bit_vrow-1:0] prdrow,
  input  logic                          pwrite,
  input  logic [remap_pkg::bit_pbnk-1:0] pwrbnk,
  input  logic [remap_pkg::bit_vrow-1:0] pwrrow,
  input  logic [remap_pkg::width-1:0]    pdin,
  output logic [remap_pkg::width-1:0]    pdout
);
  import remap_pkg::*;

  logic [num_pbnk-1:0] rd_sel;
  logic [num_pbnk-1:0] wr_sel;
  logic [width-1:0]    rd_q [num_pbnk];
  logic [bit_pbnk-1:0] rd_bnk_q;

  // one-hot bank enables
  always_comb begin
    rd_sel = '0;
    wr_sel = '0;
    if (pread) begin
      rd_sel[prdbnk] = 1'b1;
    end
    if (pwrite) begin
      wr_sel[pwrbnk] = 1'b1;
    end
  end

  for (genvar b = 0; b < num_pbnk; b++) begin : g_bank
    logic [width-1:0] mem [num_vrow];

    always_ff @(posedge clk) begin
      if (wr_sel[b]) begin
        mem[pwrrow] <= pdin;
      end
      if (rd_sel[b]) begin
        rd_q[b] <= mem[prdrow];
      end
    end
  end

  // remember which bank answered
  always_ff @(posedge clk) begin
    if (pread) begin
      rd_bnk_q <= prdbnk;
    end
  end

  assign pdout = rd_q[rd_bnk_q];

  a_single_access: assert property (
    @(posedge clk) (rd_sel & wr_sel) == '0
  );

endmodule

//--- hw/init_fsm.sv
module init_fsm (
  input  logic clk,
  input  logic rst,
  input  logic walk_last,
  output logic walk_en,
  output logic ready
);
  import remap_pkg::*;

  init_state_e state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_walk;
      ready <= 1'b0;
    end else begin
      case (state)
        st_walk: begin
          if (walk_last) begin
            state <= st_run;
          end
        end
        default: begin
          state <= st_run;
        end
      endcase
      // one cycle behind the state change
      ready <= (state == st_run);
    end
  end

  // map rows written while walking
  assign walk_en = (state == st_walk);

  // once up, ready holds until the next reset
  a_ready_sticky: assert property (
    @(posedge clk) disable iff (rst)
    ready |=> ready
  );

endmodule

//--- hw/map_table.sv
module map_table (
  input  logic                          clk,
  input  logic                          wr_look,
  input  logic [remap_pkg::bit_vrow-1:0] wr_row,
  input  logic                          rd_look,
  input  logic [remap_pkg::bit_vrow-1:0] rd_row,
  input  logic                          map_we,
  input  logic [remap_pkg::bit_vrow-1:0] map_row,
  input  logic [remap_pkg::bit_map-1:0]  map_din,
  output logic [remap_pkg::bit_map-1:0]  wr_map,
  output logic [remap_pkg::bit_map-1:0]  rd_map
);
  import remap_pkg::*;

  logic [bit_map-1:0] mem [num_vrow];

  logic wr_hit;
  logic rd_hit;

  // a write landing on a looked-up row wins over the stored entry
  assign wr_hit = map_we && (map_row == wr_row);
  assign rd_hit = map_we && (map_row == rd_row);

  always_ff @(posedge clk) begin
    if (map_we) begin
      mem[map_row] <= map_din;
    end
  end

  // lookup port for the write request
  always_ff @(posedge clk) begin
    if (wr_look) begin
      if (wr_hit) begin
        wr_map <= map_din;
      end else begin
        wr_map <= mem[wr_row];
      end
    end
  end

  // lookup port for the read request
  always_ff @(posedge clk) begin
    if (rd_look) begin
      if (rd_hit) begin
        rd_map <= map_din;
      end else begin
        rd_map <= mem[rd_row];
      end
    end
  end

endmodule

//--- hw/remap_core.sv
module remap_core (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          ready,
  input  logic                          vwrite,
  input  logic [remap_pkg::bit_addr-1:0] vwraddr,
  input  logic [remap_pkg::width-1:0]    vdin,
  input  logic                          vread,
  input  logic [remap_pkg::bit_addr-1:0] vrdaddr,
  input  logic [remap_pkg::bit_map-1:0]  wr_map,
  input  logic [remap_pkg::bit_map-1:0]  rd_map,
  output logic                          wr_look,
  output logic [remap_pkg::bit_vrow-1:0] wr_row,
  output logic                          rd_look,
  output logic [remap_pkg::bit_vrow-1:0] rd_row,
  output logic                          map_we,
  output logic [remap_pkg::bit_vrow-1:0] map_row,
  output logic [remap_pkg::bit_map-1:0]  map_din,
  output logic                          pread,
  output logic [remap_pkg::bit_pbnk-1:0] prdbnk,
  output logic [remap_pkg::bit_vrow-1:0] prdrow,
  output logic                          pwrite,
  output logic [remap_pkg::bit_pbnk-1:0] pwrbnk,
  output logic [remap_pkg::bit_vrow-1:0] pwrrow,
  output logic [remap_pkg::width-1:0]    pdin
);
  import remap_pkg::*;

  // lookup stage
  assign wr_look = vwrite && ready;
  assign wr_row  = vwraddr[bit_vrow-1:0];
  assign rd_look = vread && ready;
  assign rd_row  = vrdaddr[bit_vrow-1:0];

  logic                wr_vld_q;
  logic                rd_vld_q;
  logic [bit_vbnk-1:0] wr_vbnk_q;
  logic [bit_vrow-1:0] wr_row_q;
  logic [width-1:0]    din_q;
  logic [bit_vbnk-1:0] rd_vbnk_q;
  logic [bit_vrow-1:0] rd_row_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_vld_q <= 1'b0;
      rd_vld_q <= 1'b0;
    end else begin
      wr_vld_q <= wr_look;
      rd_vld_q <= rd_look;
    end
  end

  always_ff @(posedge clk) begin
    wr_vbnk_q <= vwraddr[bit_addr-1:bit_vrow];
    wr_row_q  <= wr_row;
    din_q     <= vdin;
    rd_vbnk_q <= vrdaddr[bit_addr-1:bit_vrow];
    rd_row_q  <= rd_row;
  end

  // resolve stage, map entries arrive this cycle
  logic [bit_pbnk-1:0] rd_pbnk;
  logic [bit_pbnk-1:0] wr_pbnk;
  logic [bit_pbnk-1:0] spare;
  logic                cflt;
  logic [bit_map-1:0]  new_map;

  assign rd_pbnk = map_field(rd_map, rd_vbnk_q);
  assign wr_pbnk = map_field(wr_map, wr_vbnk_q);
  assign spare   = map_field(wr_map, num_vbnk);
  assign cflt    = rd_vld_q && wr_vld_q && (rd_pbnk == wr_pbnk);

  // on conflict the written bank trades places with the spare
  always_comb begin
    new_map = wr_map;
    new_map[wr_vbnk_q*bit_pbnk +: bit_pbnk] = cflt ? spare : wr_pbnk;
    new_map[num_vbnk*bit_pbnk +: bit_pbnk]  = cflt ? wr_pbnk : spare;
  end

  assign map_we  = wr_vld_q;
  assign map_row = wr_row_q;
  assign map_din = new_map;

  assign pread  = rd_vld_q;
  assign prdbnk = rd_pbnk;
  assign prdrow = rd_row_q;
  assign pwrite = wr_vld_q;
  assign pwrbnk = cflt ? spare : wr_pbnk;
  assign pwrrow = wr_row_q;
  assign pdin   = din_q;

  a_no_bank_clash: assert property (
    @(posedge clk) disable iff (rst)
    (pread && pwrite) |-> (prdbnk != pwrbnk)
  );

endmodule

//--- hw/remap_mem_top.sv
module remap_mem_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          vwrite,
  input  logic [remap_pkg::bit_addr-1:0] vwraddr,
  input  logic [remap_pkg::width-1:0]    vdin,
  input  logic                          vread,
  input  logic [remap_pkg::bit_addr-1:0] vrdaddr,
  output logic [remap_pkg::width-1:0]    vdout,
  output logic                          ready
);
  import remap_pkg::*;

  logic                walk_en;
  logic                walk_last;
  logic [bit_vrow-1:0] walk_row;

  logic                wr_look;
  logic                rd_look;
  logic [bit_vrow-1:0] wr_row;
  logic [bit_vrow-1:0] rd_row;
  logic [bit_map-1:0]  wr_map;
  logic [bit_map-1:0]  rd_map;

  logic                core_map_we;
  logic [bit_vrow-1:0] core_map_row;
  logic [bit_map-1:0]  core_map_din;
  logic                map_we;
  logic [bit_vrow-1:0] map_row;
  logic [bit_map-1:0]  map_din;

  logic                pread;
  logic                pwrite;
  logic [bit_pbnk-1:0] prdbnk;
  logic [bit_pbnk-1:0] pwrbnk;
  logic [bit_vrow-1:0] prdrow;
  logic [bit_vrow-1:0] pwrrow;
  logic [width-1:0]    pdin;

  init_fsm init_fsm_i (
    .clk       (clk),
    .rst       (rst),
    .walk_last (walk_last),
    .walk_en   (walk_en),
    .ready     (ready)
  );

  row_counter row_counter_i (
    .clk       (clk),
    .rst       (rst),
    .walk_en   (walk_en),
    .walk_row  (walk_row),
    .walk_last (walk_last)
  );

  // walk owns the map write port until ready
  assign map_we  = walk_en | core_map_we;
  assign map_row = walk_en ? walk_row : core_map_row;
  assign map_din = walk_en ? map_dflt : core_map_din;

  map_table map_table_i (
    .clk     (clk),
    .wr_look (wr_look),
    .wr_row  (wr_row),
    .rd_look (rd_look),
    .rd_row  (rd_row),
    .map_we  (map_we),
    .map_row (map_row),
    .map_din (map_din),
    .wr_map  (wr_map),
    .rd_map  (rd_map)
  );

  remap_core remap_core_i (
    .clk     (clk),
    .rst     (rst),
    .ready   (ready),
    .vwrite  (vwrite),
    .vwraddr (vwraddr),
    .vdin    (vdin),
    .vread   (vread),
    .vrdaddr (vrdaddr),
    .wr_map  (wr_map),
    .rd_map  (rd_map),
    .wr_look (wr_look),
    .wr_row  (wr_row),
    .rd_look (rd_look),
    .rd_row  (rd_row),
    .map_we  (core_map_we),
    .map_row (core_map_row),
    .map_din (core_map_din),
    .pread   (pread),
    .prdbnk  (prdbnk),
    .prdrow  (prdrow),
    .pwrite  (pwrite),
    .pwrbnk  (pwrbnk),
    .pwrrow  (pwrrow),
    .pdin    (pdin)
  );

  bank_array bank_array_i (
    .clk    (clk),
    .pread  (pread),
    .prdbnk (prdbnk),
    .prdrow (prdrow),
    .pwrite (pwrite),
    .pwrbnk (pwrbnk),
    .pwrrow (pwrrow),
    .pdin   (pdin),
    .pdout  (vdout)
  );

endmodule

//--- hw/remap_pkg.sv
package remap_pkg;

  // data and address sizes
  localparam int width    = 16;
  localparam int num_vrow = 16;
  localparam int bit_vrow = 4;
  localparam int num_vbnk = 4;
  localparam int bit_vbnk = 2;
  localparam int num_pbnk = 5;
  localparam int bit_pbnk = 3;
  localparam int bit_addr = bit_vbnk + bit_vrow;

  // map entry holds one field per virtual bank, then the spare
  localparam int bit_map = bit_pbnk * num_pbnk;

  // all ones in a field means default placement
  localparam logic [bit_map-1:0] map_dflt = '1;

  typedef enum logic {
    st_walk,
    st_run
  } init_state_e;

  // physical bank held in field f, resolving the all-ones default
  function automatic logic [bit_pbnk-1:0] map_field(logic [bit_map-1:0] map, int unsigned f);
    logic [bit_pbnk-1:0] fld;
    fld = map[f*bit_pbnk +: bit_pbnk];
    if (&fld) begin
      return bit_pbnk'(f);
    end
    return fld;
  endfunction

endpackage

//--- hw/row_counter.sv
module row_counter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          walk_en,
  output logic [remap_pkg::bit_vrow-1:0] walk_row,
  output logic                          walk_last
);
  import remap_pkg::*;

  localparam logic [bit_vrow-1:0] last_row = bit_vrow'(num_vrow - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      walk_row <= '0;
    end else if (walk_en) begin
      walk_row <= walk_row + 1'b1;
    end
  end

  // final row of the walk
  assign walk_last = walk_en && (walk_row == last_row);

endmodule

//--- remap_mem.f
hw/remap_pkg.sv
hw/init_fsm.sv
hw/row_counter.sv
hw/map_table.sv
hw/remap_core.sv
hw/bank_array.sv
hw/remap_mem_top.sv
bench/remap_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -f remap_mem.f --top-module remap_mem_tb \
  -o remap_mem_sim \
  && ./obj_dir/remap_mem_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q '^\*\* PASS \*\*$' sim.log \
  && echo "simulation passed" \
  || { echo "simulation did not pass"; exit 1; }
